/* Makefile */
TOP := l2_cache_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): l2_cache.f logic/*.sv include/*.svh verification/*.sv
	verilator --binary --timing -Wno-fatal -f l2_cache.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only -Wall --timing -f l2_cache.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* l2_cache.f */
+incdir+include
logic/l2_cache_pkg.sv
logic/l2_req_arbiter.sv
logic/l2_way_store.sv
logic/l2_cache_ctrl.sv
logic/l2_cache_top.sv
verification/l2_cache_tb.sv

/* logic/l2_cache_ctrl.sv */
/*
 * cache FSM: lookup, optional victim write-back, fill, then one response.
 * takes a command only in IDLE and only after the way store sweep is done.
 * a write miss merges its word into the fill block and marks the line dirty.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_ctrl
    import l2_cache_pkg::*;
#(
    parameter  int SETS  = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = BLK_ADDR_W - IDX_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  l2_cmd_t          cmd,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    output logic [IDX_W-1:0] rd_index,
    output logic [TAG_W-1:0] lookup_tag,
    input  l2_lookup_t       lookup,
    output logic [IDX_W-1:0] wr_index,
    output logic             word_we,
    output way_t             word_way,
    output logic [1:0]       word_sel,
    output word_t            word_data,
    output logic             fill_we,
    output way_t             fill_way,
    output logic [TAG_W-1:0] fill_tag,
    output block_t           fill_data,
    output logic             dirty_we,
    output logic             dirty_val,
    output logic             touch_en,
    output way_t             touch_way,
    input  logic             init_done,
    output logic             ic_resp_valid,
    output logic             dc_resp_valid,
    output word_t            resp_data,
    output mem_req_t         mem_req,
    output logic             mem_req_valid,
    input  logic             mem_done,
    input  block_t           mem_rd_data
);

    ctrl_state_t      state;
    ctrl_state_t      state_nxt;
    l2_cmd_t          cmd_q;
    word_t            resp_q;
    logic             accept;
    logic [IDX_W-1:0] idx_q;
    logic [TAG_W-1:0] tag_q;

    assign cmd_ready = (state == IDLE) & init_done;
    assign accept    = cmd_valid & cmd_ready;

    // address split of the held command
    assign idx_q    = cmd_q.req.addr[2 +: IDX_W];
    assign tag_q    = cmd_q.req.addr[ADDR_W-1 : 2+IDX_W];
    assign word_sel = cmd_q.req.addr[1:0];

    // read the incoming set while idle, keep the held set afterwards
    assign rd_index   = (state == IDLE) ? cmd.req.addr[2 +: IDX_W] : idx_q;
    assign lookup_tag = tag_q;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) state_nxt = LOOKUP;
            end
            LOOKUP: begin
                if (lookup.hit) begin
                    state_nxt = RESPOND;
                end else if (lookup.vic_valid && lookup.vic_dirty) begin
                    state_nxt = WRITEBACK;      // victim goes back first
                end else begin
                    state_nxt = FILL;
                end
            end
            WRITEBACK: begin
                if (mem_done) state_nxt = FILL;
            end
            FILL: begin
                if (mem_done) state_nxt = RESPOND;
            end
            RESPOND: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) cmd_q <= cmd;
        if (state == LOOKUP && lookup.hit) begin
            resp_q <= lookup.hit_block[word_sel*WORD_W +: WORD_W];
        end else if (state == FILL && mem_done) begin
            resp_q <= mem_rd_data[word_sel*WORD_W +: WORD_W];
        end
    end

    ////////////////////////////////////////
    // way store writes
    ////////////////////////////////////////

    assign wr_index  = idx_q;
    assign word_we   = (state == LOOKUP) & lookup.hit & cmd_q.req.we;
    assign word_way  = lookup.hit_way;
    assign word_data = cmd_q.req.wdata;
    assign fill_we   = (state == FILL) & mem_done;
    assign fill_way  = lookup.vic_way;
    assign fill_tag  = tag_q;
    assign dirty_we  = word_we | fill_we;
    assign dirty_val = cmd_q.req.we;           // clean fill unless it carries a write
    assign touch_en  = ((state == LOOKUP) & lookup.hit) | fill_we;
    assign touch_way = lookup.hit ? lookup.hit_way : lookup.vic_way;

    always_comb begin
        fill_data = mem_rd_data;
        if (cmd_q.req.we) begin
            fill_data[word_sel*WORD_W +: WORD_W] = cmd_q.req.wdata;
        end
    end

    ////////////////////////////////////////
    // memory port and responses
    ////////////////////////////////////////

    assign mem_req_valid    = (state == WRITEBACK) | (state == FILL);
    assign mem_req.we       = (state == WRITEBACK);
    assign mem_req.blk_addr = (state == WRITEBACK) ? lookup.vic_blk_addr
                                                   : cmd_q.req.addr[ADDR_W-1:2];
    assign mem_req.wdata    = lookup.vic_block;

    assign ic_resp_valid = (state == RESPOND) & ~cmd_q.src;
    assign dc_resp_valid = (state == RESPOND) & cmd_q.src;
    assign resp_data     = resp_q;             // only meaningful on reads

endmodule

`default_nettype wire

/* logic/l2_cache_pkg.sv */
/*
 * shared widths, structs and encodings of the L2 cache controller.
 * word addressed; 4 words per block, 4 ways fixed by the 3-bit PLRU tree.
 * word 0 of a block sits in the low 32 bits.
 */
`default_nettype none

package l2_cache_pkg;

    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int ADDR_W          = 16;            // low 2 bits pick the word
    localparam int BLK_ADDR_W      = ADDR_W - 2;
    localparam int WAYS            = 4;

    typedef logic [WORD_W-1:0]                 word_t;
    typedef logic [WORDS_PER_BLOCK*WORD_W-1:0] block_t;
    typedef logic [1:0]                        way_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;                  // 1 = write one word
        word_t             wdata;
    } l2_req_t;

    typedef struct packed {
        logic    src;                           // 0 instruction side, 1 data side
        l2_req_t req;
    } l2_cmd_t;

    typedef struct packed {
        logic                  hit;
        way_t                  hit_way;
        way_t                  vic_way;
        logic                  vic_valid;
        logic                  vic_dirty;
        logic [BLK_ADDR_W-1:0] vic_blk_addr;    // where a dirty victim goes back to
        block_t                hit_block;
        block_t                vic_block;
    } l2_lookup_t;

    typedef struct packed {
        logic                  we;
        logic [BLK_ADDR_W-1:0] blk_addr;
        block_t                wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WRITEBACK = 3'd2,
        FILL      = 3'd3,
        RESPOND   = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/l2_cache_top.sv */
/*
 * L2 cache top: arbiter, way store and controller.
 * SETS must be a power of two from 4 to 256.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_top
    import l2_cache_pkg::*;
#(
    parameter  int SETS  = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = BLK_ADDR_W - IDX_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  l2_req_t  ic_req,
    input  logic     ic_valid,
    output logic     ic_ready,
    input  l2_req_t  dc_req,
    input  logic     dc_valid,
    output logic     dc_ready,
    output logic     ic_resp_valid,
    output logic     dc_resp_valid,
    output word_t    resp_data,
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_done,
    input  block_t   mem_rd_data
);

    l2_cmd_t          cmd;
    logic             cmd_valid;
    logic             cmd_ready;
    l2_lookup_t       lookup;
    logic [IDX_W-1:0] rd_index;
    logic [IDX_W-1:0] wr_index;
    logic [TAG_W-1:0] lookup_tag;
    logic [TAG_W-1:0] fill_tag;
    logic             word_we;
    way_t             word_way;
    logic [1:0]       word_sel;
    word_t            word_data;
    logic             fill_we;
    way_t             fill_way;
    block_t           fill_data;
    logic             dirty_we;
    logic             dirty_val;
    logic             touch_en;
    way_t             touch_way;
    logic             init_done;

    l2_req_arbiter arb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ic_req    (ic_req),
        .ic_valid  (ic_valid),
        .ic_ready  (ic_ready),
        .dc_req    (dc_req),
        .dc_valid  (dc_valid),
        .dc_ready  (dc_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

    l2_way_store #(.SETS(SETS)) store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index   (rd_index),
        .lookup_tag (lookup_tag),
        .lookup     (lookup),
        .wr_index   (wr_index),
        .word_we    (word_we),
        .word_way   (word_way),
        .word_sel   (word_sel),
        .word_data  (word_data),
        .fill_we    (fill_we),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag),
        .fill_data  (fill_data),
        .dirty_we   (dirty_we),
        .dirty_val  (dirty_val),
        .touch_en   (touch_en),
        .touch_way  (touch_way),
        .init_done  (init_done)
    );

    l2_cache_ctrl #(.SETS(SETS)) ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .rd_index      (rd_index),
        .lookup_tag    (lookup_tag),
        .lookup        (lookup),
        .wr_index      (wr_index),
        .word_we       (word_we),
        .word_way      (word_way),
        .word_sel      (word_sel),
        .word_data     (word_data),
        .fill_we       (fill_we),
        .fill_way      (fill_way),
        .fill_tag      (fill_tag),
        .fill_data     (fill_data),
        .dirty_we      (dirty_we),
        .dirty_val     (dirty_val),
        .touch_en      (touch_en),
        .touch_way     (touch_way),
        .init_done     (init_done),
        .ic_resp_valid (ic_resp_valid),
        .dc_resp_valid (dc_resp_valid),
        .resp_data     (resp_data),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_done      (mem_done),
        .mem_rd_data   (mem_rd_data)
    );

endmodule

`default_nettype wire

/* logic/l2_req_arbiter.sv */
/*
 * one-entry command slot in front of the controller.
 * instruction side wins when both sides are valid; dc_ready drops with ic_valid.
 * both ready signals rise one cycle after reset release.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_req_arbiter
    import l2_cache_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  l2_req_t ic_req,
    input  logic    ic_valid,
    output logic    ic_ready,
    input  l2_req_t dc_req,
    input  logic    dc_valid,
    output logic    dc_ready,
    output l2_cmd_t cmd,
    output logic    cmd_valid,
    input  logic    cmd_ready
);

    logic    rdy_en;                            // low for the first cycle out of reset
    logic    slot_full;
    l2_cmd_t slot_q;
    logic    ic_take;
    logic    dc_take;

    assign ic_ready  = rdy_en & ~slot_full;
    assign dc_ready  = rdy_en & ~slot_full & ~ic_valid;
    assign ic_take   = ic_valid & ic_ready;
    assign dc_take   = dc_valid & dc_ready;
    assign cmd       = slot_q;
    assign cmd_valid = slot_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdy_en    <= 1'b0;
            slot_full <= 1'b0;
        end else begin
            rdy_en <= 1'b1;
            if (ic_take || dc_take) begin
                slot_full <= 1'b1;
            end else if (cmd_valid && cmd_ready) begin
                slot_full <= 1'b0;              // refill possible next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ic_take) begin
            slot_q.src <= 1'b0;
            slot_q.req <= ic_req;
        end else if (dc_take) begin
            slot_q.src <= 1'b1;
            slot_q.req <= dc_req;
        end
    end

endmodule

`default_nettype wire

/* logic/l2_way_store.sv */
/*
 * tag, valid, dirty, data and PLRU arrays of a 4-way cache, read in one cycle.
 * valid, dirty and PLRU bits are swept clear over SETS cycles after reset;
 * lookups before init_done return garbage. SETS is a power of two, 4 to 256.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_way_store
    import l2_cache_pkg::*;
#(
    parameter  int SETS  = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = BLK_ADDR_W - IDX_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [IDX_W-1:0] rd_index,
    input  logic [TAG_W-1:0] lookup_tag,
    output l2_lookup_t       lookup,
    input  logic [IDX_W-1:0] wr_index,
    input  logic             word_we,
    input  way_t             word_way,
    input  logic [1:0]       word_sel,
    input  word_t            word_data,
    input  logic             fill_we,
    input  way_t             fill_way,
    input  logic [TAG_W-1:0] fill_tag,
    input  block_t           fill_data,
    input  logic             dirty_we,
    input  logic             dirty_val,
    input  logic             touch_en,
    input  way_t             touch_way,
    output logic             init_done
);

    logic [TAG_W-1:0] tag_mem  [WAYS][SETS];
    block_t           data_mem [WAYS][SETS];
    logic [WAYS-1:0]  valid_q  [SETS];
    logic [WAYS-1:0]  dirty_q  [SETS];
    logic [2:0]       plru_q   [SETS];

    logic [IDX_W-1:0] sweep_idx;
    logic [IDX_W-1:0] rd_index_q;
    logic [TAG_W-1:0] rd_tag   [WAYS];
    block_t           rd_data  [WAYS];
    logic [WAYS-1:0]  rd_valid;
    logic [WAYS-1:0]  rd_dirty;
    logic [2:0]       rd_plru;
    logic [2:0]       plru_next;
    way_t             dirty_way;
    logic             any_free;

    ////////////////////////////////////////
    // state bits and reset sweep
    ////////////////////////////////////////

    // fill takes the dirty bit with it, otherwise it follows the word write
    assign dirty_way = fill_we ? fill_way : word_way;

    always_comb begin
        plru_next = plru_q[wr_index];
        if (!touch_way[1]) begin
            plru_next[0] = 1'b1;                // root to pair 2/3
            plru_next[1] = ~touch_way[0];
        end else begin
            plru_next[0] = 1'b0;                // root to pair 0/1
            plru_next[2] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_idx <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            valid_q[sweep_idx] <= '0;
            dirty_q[sweep_idx] <= '0;
            plru_q[sweep_idx]  <= '0;
            sweep_idx          <= sweep_idx + 1'b1;
            if (sweep_idx == IDX_W'(SETS - 1)) begin
                init_done <= 1'b1;
            end
        end else begin
            if (fill_we) valid_q[wr_index][fill_way] <= 1'b1;
            if (dirty_we) dirty_q[wr_index][dirty_way] <= dirty_val;
            if (touch_en) plru_q[wr_index] <= plru_next;
        end
    end

    ////////////////////////////////////////
    // tag and data arrays, registered read
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_way][wr_index]  <= fill_tag;
            data_mem[fill_way][wr_index] <= fill_data;
        end
        if (word_we) begin
            data_mem[word_way][wr_index][word_sel*WORD_W +: WORD_W] <= word_data;
        end
        for (int w = 0; w < WAYS; w++) begin
            rd_tag[w]  <= tag_mem[w][rd_index];
            rd_data[w] <= data_mem[w][rd_index];
        end
        rd_valid   <= valid_q[rd_index];
        rd_dirty   <= dirty_q[rd_index];
        rd_plru    <= plru_q[rd_index];
        rd_index_q <= rd_index;
    end

    // lowest matching way is the hit, lowest free way the victim
    always_comb begin
        lookup          = '0;
        any_free        = 1'b0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (rd_valid[w] && (rd_tag[w] == lookup_tag)) begin
                lookup.hit     = 1'b1;
                lookup.hit_way = way_t'(w);
            end
            if (!rd_valid[w]) begin
                any_free       = 1'b1;
                lookup.vic_way = way_t'(w);
            end
        end
        if (!any_free) begin
            lookup.vic_way = rd_plru[0] ? {1'b1, rd_plru[2]} : {1'b0, rd_plru[1]};
        end
        lookup.vic_valid    = rd_valid[lookup.vic_way];
        lookup.vic_dirty    = rd_dirty[lookup.vic_way];
        lookup.vic_blk_addr = {rd_tag[lookup.vic_way], rd_index_q};
        lookup.hit_block    = rd_data[lookup.hit_way];
        lookup.vic_block    = rd_data[lookup.vic_way];
    end

endmodule

`default_nettype wire

/* include/l2_cache_model.svh */
/*
 * reference model and memory responder, included inside the testbench module.
 * needs SETS, IDX_W, TAG_W, DRIVE_DLY, the DUT memory signals and the check tasks.
 * blocks keep word 0 in the low 32 bits; memory latency is 1 to 4 cycles.
 */
`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

typedef struct packed {
    logic  src;                                 // 1 = data side
    logic  is_read;
    logic  hit;
    word_t data;
} exp_resp_t;

typedef struct packed {
    logic [BLK_ADDR_W-1:0] blk_addr;
    block_t                data;
} exp_wb_t;

word_t            mem_words [1 << ADDR_W];      // what memory holds now
word_t            shadow    [1 << ADDR_W];      // latest value written per word
logic [TAG_W-1:0] m_tag     [SETS][WAYS];
logic [WAYS-1:0]  m_valid   [SETS];
logic [WAYS-1:0]  m_dirty   [SETS];
logic [2:0]       m_plru    [SETS];
exp_resp_t        resp_q[$];
exp_wb_t          wb_q[$];
int               miss_cnt;
int               wb_cnt;
int               mem_rd_cnt;
int               mem_wr_cnt;

function automatic word_t init_word(input logic [ADDR_W-1:0] a);
    return {~a, a} ^ 32'h3c5a_0000;
endfunction

function automatic block_t shadow_block(input logic [BLK_ADDR_W-1:0] b);
    return {shadow[{b, 2'd3}], shadow[{b, 2'd2}], shadow[{b, 2'd1}], shadow[{b, 2'd0}]};
endfunction

task automatic model_reset();
    for (int i = 0; i < (1 << ADDR_W); i++) begin
        mem_words[i] = init_word(ADDR_W'(i));
        shadow[i]    = mem_words[i];
    end
    for (int s = 0; s < SETS; s++) begin
        m_valid[s] = '0;
        m_dirty[s] = '0;
        m_plru[s]  = '0;
    end
    miss_cnt   = 0;
    wb_cnt     = 0;
    mem_rd_cnt = 0;
    mem_wr_cnt = 0;
endtask

// apply one accepted request to the model, in acceptance order
task automatic predict(input logic src, input l2_req_t req);
    logic [BLK_ADDR_W-1:0] blk;
    logic [IDX_W-1:0]      idx;
    logic [TAG_W-1:0]      tag;
    way_t                  way;
    logic                  hit;
    logic                  found;
    exp_resp_t             want;
    exp_wb_t               wb;
    blk   = req.addr[ADDR_W-1:2];
    idx   = blk[IDX_W-1:0];
    tag   = blk[BLK_ADDR_W-1:IDX_W];
    way   = 2'd0;
    hit   = 1'b0;
    found = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
        if (!hit && m_valid[idx][w] && m_tag[idx][w] == tag) begin
            hit = 1'b1;
            way = way_t'(w);
        end
    end
    if (!hit) begin
        miss_cnt++;
        for (int w = 0; w < WAYS; w++) begin
            if (!found && !m_valid[idx][w]) begin
                found = 1'b1;
                way   = way_t'(w);
            end
        end
        if (!found) begin                       // no free way so the tree decides
            way = m_plru[idx][0] ? {1'b1, m_plru[idx][2]} : {1'b0, m_plru[idx][1]};
        end
        if (m_valid[idx][way] && m_dirty[idx][way]) begin
            wb.blk_addr = {m_tag[idx][way], idx};
            wb.data     = shadow_block(wb.blk_addr);
            wb_q.push_back(wb);
            wb_cnt++;
        end
        m_tag[idx][way]   = tag;
        m_valid[idx][way] = 1'b1;
        m_dirty[idx][way] = 1'b0;
    end
    if (req.we) begin
        shadow[req.addr]  = req.wdata;
        m_dirty[idx][way] = 1'b1;
    end
    m_plru[idx][0] = ~way[1];                   // root away from the used pair
    if (way[1]) begin
        m_plru[idx][2] = ~way[0];
    end else begin
        m_plru[idx][1] = ~way[0];
    end
    want.src     = src;
    want.is_read = ~req.we;
    want.hit     = hit;
    want.data    = shadow[req.addr];
    resp_q.push_back(want);
endtask

initial begin : mem_responder
    mem_req_t req;
    exp_wb_t  want;
    int       delay;
    mem_done    = 1'b0;
    mem_rd_data = '0;
    forever begin
        @(negedge clk);
        if (rst_n && mem_req_valid) begin
            req   = mem_req;
            delay = 1 + int'($urandom % 4);
            repeat (delay) @(posedge clk);
            #DRIVE_DLY;
            if (req.we) begin
                mem_wr_cnt++;
                if (wb_q.size() == 0) begin
                    stop_run("memory write seen with no dirty eviction predicted");
                end else begin
                    want = wb_q.pop_front();
                    check_value("writeback address", 128'(want.blk_addr), 128'(req.blk_addr));
                    check_value("writeback data", want.data, req.wdata);
                    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
                        mem_words[{req.blk_addr, 2'(i)}] = req.wdata[i*WORD_W +: WORD_W];
                    end
                end
            end else begin
                mem_rd_cnt++;
                mem_rd_data = {mem_words[{req.blk_addr, 2'd3}], mem_words[{req.blk_addr, 2'd2}],
                               mem_words[{req.blk_addr, 2'd1}], mem_words[{req.blk_addr, 2'd0}]};
            end
            mem_done = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            mem_done = 1'b0;
        end
    end
end

`endif

/* verification/l2_cache_tb.sv */
/*
 * random regression of the L2 cache top against the included model.
 * SETS is 16 here and in the model; a few tags over 3 sets force evictions.
 * inputs change 2 ns after the rising edge, outputs are read on the falling edge.
 */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb
    import l2_cache_pkg::*;
();

    localparam int SETS         = 16;
    localparam int IDX_W        = $clog2(SETS);
    localparam int TAG_W        = BLK_ADDR_W - IDX_W;
    localparam int NUM_OPS      = 400;
    localparam int OP_CYCLES    = 20;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 1888;

    logic     clk;
    logic     rst_n;
    l2_req_t  ic_req;
    logic     ic_valid;
    logic     ic_ready;
    l2_req_t  dc_req;
    logic     dc_valid;
    logic     dc_ready;
    logic     ic_resp_valid;
    logic     dc_resp_valid;
    word_t    resp_data;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_done;
    block_t   mem_rd_data;
    int       take_q[$];                        // cycle each command entered the controller

    l2_cache_top #(.SETS(SETS)) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ic_req        (ic_req),
        .ic_valid      (ic_valid),
        .ic_ready      (ic_ready),
        .dc_req        (dc_req),
        .dc_valid      (dc_valid),
        .dc_ready      (dc_ready),
        .ic_resp_valid (ic_resp_valid),
        .dc_resp_valid (dc_resp_valid),
        .resp_data     (resp_data),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_done      (mem_done),
        .mem_rd_data   (mem_rd_data)
    );

    ////////////////////////////////////////
    // failure reporting and checks
    ////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("FAIL %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    task automatic check_quiet(input string name);
        check_value(name, 128'(0),
                    128'({ic_ready, dc_ready, ic_resp_valid, dc_resp_valid, mem_req_valid}));
    endtask

    task automatic random_request(output l2_req_t req);
        logic [TAG_W-1:0] tag;
        tag       = TAG_W'(($urandom % 6) * 37 + 1);    // six tags share each set
        req.addr  = {tag, IDX_W'($urandom % 3), 2'($urandom % 4)};
        req.we    = ($urandom % 3) == 0;
        req.wdata = $urandom;
    endtask

    `include "l2_cache_model.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 400 ops at 20 cycles each bounds the run
    initial begin : watchdog
        #(NUM_OPS * OP_CYCLES * CLK_PERIOD);
        stop_run("the run timed out before all operations were answered");
    end

    ////////////////////////////////////////
    // stimulus and response checking
    ////////////////////////////////////////

    initial begin : main
        int        cyc;
        int        issued;
        int        take;
        logic      ic_sent;
        logic      dc_sent;
        logic      slot_busy;
        exp_resp_t want;
        void'($urandom(SEED));
        model_reset();
        rst_n     = 1'b0;
        ic_valid  = 1'b0;
        dc_valid  = 1'b0;
        ic_req    = '0;
        dc_req    = '0;
        cyc       = 0;
        issued    = 0;
        ic_sent   = 1'b0;
        dc_sent   = 1'b0;
        slot_busy = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_quiet("outputs low during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet("outputs low right after reset");
        while (issued < NUM_OPS || ic_valid || dc_valid || resp_q.size() > 0) begin
            @(posedge clk);
            cyc++;
            #DRIVE_DLY;
            if (ic_sent) begin
                ic_valid = 1'b0;
                ic_sent  = 1'b0;
            end
            if (dc_sent) begin
                dc_valid = 1'b0;
                dc_sent  = 1'b0;
            end
            if (!ic_valid && issued < NUM_OPS && $urandom % 2 == 0) begin
                random_request(ic_req);
                ic_valid = 1'b1;
                issued++;
            end
            if (!dc_valid && issued < NUM_OPS && $urandom % 2 == 0) begin
                random_request(dc_req);
                dc_valid = 1'b1;
                issued++;
            end
            @(negedge clk);
            if (slot_busy && ic_ready) begin    // slot emptied into the controller
                take_q.push_back(cyc);
                slot_busy = 1'b0;
            end
            if (ic_resp_valid || dc_resp_valid) begin
                if (resp_q.size() == 0 || take_q.size() == 0) begin
                    stop_run("a response arrived with no request in flight");
                end else begin
                    want = resp_q.pop_front();
                    take = take_q.pop_front();
                    check_value("one response valid", 128'(1),
                                128'(ic_resp_valid ^ dc_resp_valid));
                    check_value("response side", 128'(want.src), 128'(dc_resp_valid));
                    if (want.is_read) begin
                        check_value("read data", 128'(want.data), 128'(resp_data));
                    end
                    if (want.hit) begin
                        check_value("hit latency", 128'(2), 128'(cyc + 1 - take));
                    end
                end
            end
            if (ic_valid && dc_valid && ic_ready) begin
                check_value("dc_ready under ic priority", 128'(0), 128'(dc_ready));
            end
            if (ic_valid && ic_ready) begin
                predict(1'b0, ic_req);
                ic_sent   = 1'b1;
                slot_busy = 1'b1;
            end else if (dc_valid && dc_ready) begin
                predict(1'b1, dc_req);
                dc_sent   = 1'b1;
                slot_busy = 1'b1;
            end
        end
        check_value("memory reads", 128'(miss_cnt), 128'(mem_rd_cnt));
        check_value("memory writes", 128'(wb_cnt), 128'(mem_wr_cnt));
        check_value("writebacks left over", 128'(0), 128'(wb_q.size()));
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
